//--- rtl/panelPkg.sv
package panelPkg;

    localparam int SwWidth  = 10;  // Slide switch bank
    localparam int KeyWidth = 4;   // Push keys, active low on the board

    // Field view of the switch bank, LSB first on the board
    typedef struct packed
    {
        logic [7:0] dataByte;   // sw[9:2]
        logic       showCount;  // sw[1]
        logic       editMode;   // sw[0]
    } swFields_t;

    // One switch word read two ways
    // The raw view drives the red LEDs and the field view steers the logic
    typedef union packed
    {
        logic [SwWidth-1:0] raw;
        swFields_t          fields;
    } swWord_u;

endpackage

//--- rtl/storePkg.sv
package storePkg;

    // Number of bytes the store holds unless the top says otherwise
    localparam int DefaultDepth = 16;

    // Entry count width, wide enough for the 7-bit count on hex3/hex2
    localparam int CountWidth = 7;

    // Hold time of the key filter in clk18 cycles
    localparam int DefaultHold = 10800;  // 0.6 ms at 18 MHz

endpackage

//--- rtl/panelRegs.sv
module panelRegs (
    input  logic                         clk18,
    input  logic                         reset,
    input  logic [panelPkg::SwWidth-1:0] sw,
    input  logic [panelPkg::KeyWidth-1:0] key,
    input  logic                         clearN,
    output panelPkg::swWord_u            swSync,
    output logic [panelPkg::KeyWidth-1:0] keySync,
    output logic                         writeKey,
    output logic                         backKey,
    output logic                         stepKey,
    output logic                         clearSync
);
    import panelPkg::*;

    // First synchronizer stage
    logic [SwWidth-1:0]  swMeta;
    logic [KeyWidth-1:0] keyMeta;
    logic                clearMeta;
    logic                editMode;  // High in edit mode, low in browse mode

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            swMeta    <= '0;
            swSync    <= '0;
            keyMeta   <= '1;  // Keys read released
            keySync   <= '1;
            clearMeta <= 1'b1;
            clearSync <= 1'b1;
        end
        else
        begin
            swMeta    <= sw;
            swSync    <= swMeta;
            keyMeta   <= key;
            keySync   <= keyMeta;
            clearMeta <= clearN;
            clearSync <= clearMeta;
        end
    end

    assign editMode = swSync.fields.editMode;

    // Mode gating, a blocked key looks released to its filter
    assign writeKey = editMode ? keySync[0] : 1'b1;  // key0 writes
    assign backKey  = editMode ? keySync[1] : 1'b1;  // key1 removes
    assign stepKey  = editMode ? 1'b1 : keySync[3];  // key3 steps the cursor

endmodule

//--- rtl/keyDebounce.sv
module keyDebounce #(
    parameter int HoldCycles = storePkg::DefaultHold
) (
    input  logic clk18,
    input  logic reset,
    input  logic keyN,   // Active low, already synchronized
    output logic pulse   // One cycle per press
);

    // One spare bit so HoldCycles itself always fits
    localparam int CntWidth = $clog2(HoldCycles) + 1;

    logic [CntWidth-1:0] holdCount;
    logic                done;  // Pulse already given for this press

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            holdCount <= '0;
            done      <= 1'b0;
            pulse     <= 1'b0;
        end
        else if (keyN)
        begin
            // Released, arm for the next press
            holdCount <= '0;
            done      <= 1'b0;
            pulse     <= 1'b0;
        end
        else
        begin
            pulse <= 1'b0;
            if (!done)
            begin
                if (holdCount == CntWidth'(HoldCycles - 1))
                begin
                    pulse <= 1'b1;  // Low for HoldCycles samples in a row
                    done  <= 1'b1;
                end
                else
                begin
                    holdCount <= holdCount + 1'b1;
                end
            end
        end
    end

    // A held key never gives back-to-back pulses
    pulseSingle: assert property (@(posedge clk18) disable iff (reset)
        pulse |=> !pulse);

endmodule

//--- rtl/byteStore.sv
module byteStore #(
    parameter int Depth = storePkg::DefaultDepth
) (
    input  logic                             clk18,
    input  logic                             reset,
    input  logic                             writePulse,
    input  logic                             backPulse,
    input  logic                             stepPulse,
    input  logic                             clearPulse,
    input  logic [7:0]                       dataIn,
    output logic [7:0]                       lastByte,
    output logic [7:0]                       browseByte,
    output logic [storePkg::CountWidth-1:0]  entryCount
);
    import storePkg::*;

    localparam int IdxWidth = (Depth > 1) ? $clog2(Depth) : 1;

    logic [7:0]            mem [Depth];  // Payload only
    logic [CountWidth-1:0] count;        // Entries held
    logic [CountWidth-1:0] cursor;       // Browse position
    logic [CountWidth-1:0] nextCount;
    logic [CountWidth-1:0] nextCursor;
    logic [CountWidth-1:0] newestIdx;
    logic                  doWrite;

    // Clear beats write beats back beats step
    always_comb
    begin
        nextCount  = count;
        nextCursor = cursor;
        doWrite    = 1'b0;
        if (clearPulse)
        begin
            nextCount  = '0;
            nextCursor = '0;
        end
        else if (writePulse)
        begin
            if (count < CountWidth'(Depth))  // Full store drops the write
            begin
                nextCount = count + 1'b1;
                doWrite   = 1'b1;
            end
        end
        else if (backPulse)
        begin
            if (count != '0)
            begin
                nextCount = count - 1'b1;
                // Cursor on the removed entry moves down one
                if (cursor == count - 1'b1 && cursor != '0)
                    nextCursor = cursor - 1'b1;
            end
        end
        else if (stepPulse && count != '0)
        begin
            nextCursor = (cursor == count - 1'b1) ? '0 : cursor + 1'b1;  // Wrap
        end
    end

    assign newestIdx = nextCount - 1'b1;

    always_ff @(posedge clk18)
    begin
        if (doWrite)
            mem[count[IdxWidth-1:0]] <= dataIn;  // Append at the fill mark
    end

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            count      <= '0;
            cursor     <= '0;
            lastByte   <= '0;
            browseByte <= '0;
        end
        else
        begin
            count  <= nextCount;
            cursor <= nextCursor;
            // Outputs follow the new state, the fresh byte is forwarded
            if (nextCount == '0)
                lastByte <= '0;
            else if (doWrite)
                lastByte <= dataIn;
            else
                lastByte <= mem[newestIdx[IdxWidth-1:0]];
            if (nextCount == '0)
                browseByte <= '0;
            else if (doWrite && nextCursor == count)
                browseByte <= dataIn;  // First entry of an empty store
            else
                browseByte <= mem[nextCursor[IdxWidth-1:0]];
        end
    end

    assign entryCount = count;

    countBound: assert property (@(posedge clk18) disable iff (reset)
        entryCount <= CountWidth'(Depth));

    cursorInside: assert property (@(posedge clk18) disable iff (reset)
        (count != '0) |-> (cursor < count));

endmodule

//--- rtl/displayDriver.sv
module displayDriver #(
    parameter int BlinkBits = 23
) (
    input  logic                            clk18,
    input  logic                            reset,
    input  panelPkg::swWord_u               swSync,
    input  logic [panelPkg::KeyWidth-1:0]   keySync,
    input  logic [7:0]                      lastByte,
    input  logic [7:0]                      browseByte,
    input  logic [storePkg::CountWidth-1:0] entryCount,
    output logic [6:0]                      hex0,
    output logic [6:0]                      hex1,
    output logic [6:0]                      hex2,
    output logic [6:0]                      hex3,
    output logic [7:0]                      ledG,
    output logic [panelPkg::SwWidth-1:0]    ledR
);
    import panelPkg::*;

    logic [BlinkBits-1:0] blinkCnt;
    logic [7:0]           lowByte;   // hex1/hex0 source
    logic [7:0]           highByte;  // hex3/hex2 source
    logic                 blank;

    // Active-low segments, gfedcba
    function automatic logic [6:0] hexSeg(input logic [3:0] nib);
        case (nib)
            4'h0: hexSeg = 7'b1000000;
            4'h1: hexSeg = 7'b1111001;
            4'h2: hexSeg = 7'b0100100;
            4'h3: hexSeg = 7'b0110000;
            4'h4: hexSeg = 7'b0011001;
            4'h5: hexSeg = 7'b0010010;
            4'h6: hexSeg = 7'b0000010;
            4'h7: hexSeg = 7'b1111000;
            4'h8: hexSeg = 7'b0000000;
            4'h9: hexSeg = 7'b0011000;
            4'ha: hexSeg = 7'b0001000;
            4'hb: hexSeg = 7'b0000011;
            4'hc: hexSeg = 7'b1000110;
            4'hd: hexSeg = 7'b0100001;
            4'he: hexSeg = 7'b0000110;
            default: hexSeg = 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clk18)
    begin
        if (reset)
            blinkCnt <= '0;
        else
            blinkCnt <= blinkCnt + 1'b1;  // Free running
    end

    assign lowByte  = swSync.fields.editMode ? swSync.fields.dataByte : browseByte;
    assign highByte = swSync.fields.showCount ? 8'(entryCount) : lastByte;
    // Empty store blanks during the low half of the blink period
    assign blank    = (entryCount == '0) && !blinkCnt[BlinkBits-1];

    assign hex0 = blank ? 7'h7f : hexSeg(lowByte[3:0]);
    assign hex1 = blank ? 7'h7f : hexSeg(lowByte[7:4]);
    assign hex2 = blank ? 7'h7f : hexSeg(highByte[3:0]);
    assign hex3 = blank ? 7'h7f : hexSeg(highByte[7:4]);

    // Edit mode puts key i on LED 2i+1, browse mode shows the entry
    always_comb
    begin
        ledG = browseByte;
        if (swSync.fields.editMode)
        begin
            ledG = '0;
            for (int i = 0; i < KeyWidth; i++)
                ledG[2*i+1] = ~keySync[i];  // Lit while held
        end
    end

    assign ledR = swSync.raw;

endmodule

//--- rtl/keyLoggerTop.sv
module keyLoggerTop #(
    parameter int Depth      = storePkg::DefaultDepth,
    parameter int HoldCycles = storePkg::DefaultHold,
    parameter int BlinkBits  = 23   // About 2 Hz full blink at 18 MHz
) (
    input  logic                          clk18,
    input  logic                          reset,
    input  logic                          clearN,
    input  logic [panelPkg::KeyWidth-1:0] key,
    input  logic [panelPkg::SwWidth-1:0]  sw,
    output logic [6:0]                    hex0,
    output logic [6:0]                    hex1,
    output logic [6:0]                    hex2,
    output logic [6:0]                    hex3,
    output logic [7:0]                    ledG,
    output logic [panelPkg::SwWidth-1:0]  ledR
);
    import panelPkg::*;
    import storePkg::*;

    swWord_u               swSync;
    logic [KeyWidth-1:0]   keySync;
    logic                  writeKey;    // Mode gated, active low
    logic                  backKey;
    logic                  stepKey;
    logic                  clearSync;
    logic                  writePulse;
    logic                  backPulse;
    logic                  stepPulse;
    logic                  clearPulse;
    logic [7:0]            lastByte;
    logic [7:0]            browseByte;
    logic [CountWidth-1:0] entryCount;

    panelRegs u_panelRegs (
        .clk18, .reset, .sw, .key, .clearN,
        .swSync, .keySync, .writeKey, .backKey, .stepKey, .clearSync
    );

    keyDebounce #(.HoldCycles(HoldCycles)) u_writeDeb (
        .clk18, .reset, .keyN(writeKey), .pulse(writePulse)
    );

    keyDebounce #(.HoldCycles(HoldCycles)) u_backDeb (
        .clk18, .reset, .keyN(backKey), .pulse(backPulse)
    );

    keyDebounce #(.HoldCycles(HoldCycles)) u_stepDeb (
        .clk18, .reset, .keyN(stepKey), .pulse(stepPulse)
    );

    // Clear input gets the same hold filter as the keys
    keyDebounce #(.HoldCycles(HoldCycles)) u_clearDeb (
        .clk18, .reset, .keyN(clearSync), .pulse(clearPulse)
    );

    byteStore #(.Depth(Depth)) u_byteStore (
        .clk18, .reset, .writePulse, .backPulse, .stepPulse, .clearPulse,
        .dataIn(swSync.fields.dataByte),
        .lastByte, .browseByte, .entryCount
    );

    displayDriver #(.BlinkBits(BlinkBits)) u_display (
        .clk18, .reset, .swSync, .keySync, .lastByte, .browseByte, .entryCount,
        .hex0, .hex1, .hex2, .hex3, .ledG, .ledR
    );

endmodule

//--- bench/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Active-low hex digits, gfedcba
localparam logic [6:0] SegTable [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
};

task automatic reportMismatch(input string port, input logic [9:0] expected,
                              input logic [9:0] actual);
    $display("FAIL %s %s: expected %h actual %h", testName, port, expected, actual);
    $display("CHECKS FAILED");
    $fatal(1, "Port %s differs from the reference model", port);
endtask

// Digits and LEDs against the model, only in settled windows
hex0Check: assert property (@(posedge clk18) disable iff (!checkOn) hex0 == expHex0)
    else reportMismatch("hex0", 10'($sampled(expHex0)), 10'($sampled(hex0)));
hex1Check: assert property (@(posedge clk18) disable iff (!checkOn) hex1 == expHex1)
    else reportMismatch("hex1", 10'($sampled(expHex1)), 10'($sampled(hex1)));
hex2Check: assert property (@(posedge clk18) disable iff (!checkOn) hex2 == expHex2)
    else reportMismatch("hex2", 10'($sampled(expHex2)), 10'($sampled(hex2)));
hex3Check: assert property (@(posedge clk18) disable iff (!checkOn) hex3 == expHex3)
    else reportMismatch("hex3", 10'($sampled(expHex3)), 10'($sampled(hex3)));
ledGCheck: assert property (@(posedge clk18) disable iff (!checkOn) ledG == expLedG)
    else reportMismatch("ledG", 10'($sampled(expLedG)), 10'($sampled(ledG)));
ledRCheck: assert property (@(posedge clk18) disable iff (!swSettled) ledR == sw)
    else reportMismatch("ledR", $sampled(sw), $sampled(ledR));  // Red LEDs mirror sw

`endif

//--- bench/tbKeyLogger.sv
module tbKeyLogger;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HoldCycles    = 8;
    localparam int Depth         = 4;
    localparam int PressCycles   = HoldCycles + 16;         // Hold, release, look
    localparam int TimeoutCycles = 60 * PressCycles + 200;  // 60 presses plus margin
    localparam logic [4:0] WriteKey = 5'b00001;             // {clearN, key} active bits
    localparam logic [4:0] BackKey  = 5'b00010;
    localparam logic [4:0] StepKey  = 5'b01000;
    localparam logic [4:0] ClearKey = 5'b10000;

    logic       clk18 = 1'b0;
    logic       reset;
    logic       clearN;
    logic [3:0] key;
    logic [9:0] sw;
    logic [6:0] hex0, hex1, hex2, hex3;
    logic [7:0] ledG;
    logic [9:0] ledR;

    logic [7:0] modelMem [Depth];  // Store model
    logic [2:0] modelCount;
    logic [1:0] modelCursor;
    logic [3:0] blinkRef;          // Same period as BlinkBits 4
    logic [7:0] lastExp;
    logic [7:0] browseExp;
    logic [7:0] lowExp;
    logic [7:0] highExp;
    logic       blankExp;
    logic [6:0] expHex0, expHex1, expHex2, expHex3;
    logic [7:0] expLedG;
    logic       checkOn;
    logic       swSettled;
    string      testName;
    integer     seed;
    int         cycleCount = 0;
    logic       sawBlank;
    logic       sawLit;

    keyLoggerTop #(.Depth(Depth), .HoldCycles(HoldCycles), .BlinkBits(4)) u_dut (
        .clk18, .reset, .clearN, .key, .sw, .hex0, .hex1, .hex2, .hex3, .ledG, .ledR
    );

    `include "tbChecks.svh"

    always_comb
    begin
        lastExp   = (modelCount == 3'd0) ? 8'h00 : modelMem[modelCount[1:0] - 2'd1];
        browseExp = (modelCount == 3'd0) ? 8'h00 : modelMem[modelCursor];
        lowExp    = sw[0] ? sw[9:2] : browseExp;        // Edit shows the switches
        highExp   = sw[1] ? 8'(modelCount) : lastExp;   // Count or newest byte
        blankExp  = (modelCount == 3'd0) && !blinkRef[3];
        expHex0   = blankExp ? 7'h7f : SegTable[lowExp[3:0]];
        expHex1   = blankExp ? 7'h7f : SegTable[lowExp[7:4]];
        expHex2   = blankExp ? 7'h7f : SegTable[highExp[3:0]];
        expHex3   = blankExp ? 7'h7f : SegTable[highExp[7:4]];
        expLedG   = browseExp;
        if (sw[0])
            expLedG = {~key[3], 1'b0, ~key[2], 1'b0, ~key[1], 1'b0, ~key[0], 1'b0};
    end

    initial
    begin
        forever #20 clk18 = ~clk18;  // 40 ns period
    end

    always @(posedge clk18)
    begin
        blinkRef   <= reset ? 4'h0 : blinkRef + 1'b1;
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles)
        begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
            $display("CHECKS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Ends 5 ns after the n-th rising edge
    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk18);
        #5;
    endtask

    task automatic observe(input int n);
        checkOn = 1'b1;
        waitCycles(n);
    endtask

    task automatic setSwitches(input logic edit, input logic showCnt, input logic [7:0] data);
        checkOn   = 1'b0;
        swSettled = 1'b0;
        sw        = {data, showCnt, edit};
        waitCycles(3);  // Two sync stages
        swSettled = 1'b1;
        observe(4);
    endtask

    task automatic pressKey(input logic [4:0] mask);
        checkOn       = 1'b0;
        {clearN, key} = ~mask;
        waitCycles(HoldCycles + 6);  // Sync plus hold plus store update
        {clearN, key} = 5'h1f;
        waitCycles(4);
        if (mask[4])
        begin
            modelCount  = 3'd0;
            modelCursor = 2'd0;
        end
        else if (mask[0] && sw[0] && modelCount < 3'(Depth))
        begin
            modelMem[modelCount[1:0]] = sw[9:2];
            modelCount                = modelCount + 3'd1;
        end
        else if (mask[1] && sw[0] && modelCount != 3'd0)
        begin
            modelCount = modelCount - 3'd1;
            if ({1'b0, modelCursor} >= modelCount && modelCursor != 2'd0)
                modelCursor = modelCount[1:0] - 2'd1;  // Cursor back inside
        end
        else if (mask[3] && !sw[0] && modelCount != 3'd0)
            modelCursor = ({1'b0, modelCursor} == modelCount - 3'd1) ? 2'd0 : modelCursor + 2'd1;
        observe(6);
    endtask

    initial
    begin
        seed        = 77512;
        reset       = 1'b1;
        clearN      = 1'b1;
        key         = 4'hf;
        sw          = '0;
        checkOn     = 1'b0;
        swSettled   = 1'b0;
        modelCount  = 3'd0;
        modelCursor = 2'd0;
        testName    = "reset";
        waitCycles(5);
        reset     = 1'b0;
        swSettled = 1'b1;
        observe(4);

        testName = "write";
        repeat (5)  // Fifth one hits a full store
        begin
            setSwitches(1'b1, 1'b1, 8'($random(seed)));
            pressKey(WriteKey);
        end
        setSwitches(1'b1, 1'b0, sw[9:2]);  // Newest byte on hex3/hex2

        testName = "back";
        repeat (5) pressKey(BackKey);  // Last one on an empty store
        setSwitches(1'b1, 1'b1, sw[9:2]);
        observe(20);

        testName = "browse";
        repeat (3)
        begin
            setSwitches(1'b1, 1'b0, 8'($random(seed)));
            pressKey(WriteKey);
        end
        setSwitches(1'b0, 1'b0, sw[9:2]);
        repeat (4) pressKey(StepKey);  // Wraps past the third entry
        setSwitches(1'b0, 1'b1, sw[9:2]);  // Count on hex3/hex2 exposes a stray write
        pressKey(WriteKey);            // Blocked in browse mode
        pressKey(BackKey);

        testName = "clear";
        pressKey(ClearKey);
        sawBlank = 1'b0;
        sawLit   = 1'b0;
        repeat (16)  // One blink period
        begin
            waitCycles(1);
            if (hex0 == 7'h7f)
                sawBlank = 1'b1;
            else
                sawLit = 1'b1;
        end
        assert (sawBlank && sawLit)
        else
        begin
            $display("Blink check: the empty store did not show both phases in one period");
            $display("CHECKS FAILED");
            $fatal(1, "Empty store did not blink");
        end

        testName = "leds";
        setSwitches(1'b1, 1'b0, 8'($random(seed)));
        pressKey(WriteKey);
        checkOn = 1'b0;
        key     = 4'b0011;  // Keys 2 and 3 have no job in edit mode
        waitCycles(3);
        observe(6);
        key = 4'hf;
        setSwitches(1'b0, 1'b1, sw[9:2]);  // ledG now shows the browsed byte

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+bench
rtl/panelPkg.sv
rtl/storePkg.sv
rtl/panelRegs.sv
rtl/keyDebounce.sv
rtl/byteStore.sv
rtl/displayDriver.sv
rtl/keyLoggerTop.sv
bench/tbKeyLogger.sv

//--- run.sh
#!/bin/sh
# Build and run the keyLogger testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbKeyLogger -f build.f -o simKeyLogger
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simKeyLogger
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0
